// ==== Bender.yml ====
package:
  name: adpcm_drv_a

sources:
  - adpcm_pkg.sv
  - adpcm_slot_seq.sv
  - adpcm_addr_cnt.sv
  - adpcm_decoder.sv
  - adpcm_gain.sv
  - adpcm_mix.sv
  - adpcm_drv_a.sv
  - target: test
    files:
      - adpcm_drv_a_chk.sv
      - tb_adpcm_drv_a.sv

// ==== adpcm_addr_cnt.sv ====
`timescale 1ns/100ps

module adpcm_addr_cnt (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              cen,
    input  logic [adpcm_pkg::ch_w-1:0]        seq_ch,
    input  adpcm_pkg::reg_op_e                seq_op,
    input  logic [adpcm_pkg::reg_addr_w-1:0]  seq_val,
    output logic [adpcm_pkg::addr_w-1:0]      rom_addr,
    output logic                              rom_oe_n,
    output logic [adpcm_pkg::ch_w-1:0]        ac_ch,
    output logic                              ac_nib_hi,  // high nibble of rom_data
    output logic                              ac_on,
    output logic [adpcm_pkg::ch_w-1:0]        pan_ch,
    output logic                              pan_wr,
    output logic [7:0]                        pan_val
);

    logic [adpcm_pkg::addr_w-1:0] start_a [adpcm_pkg::num_ch];
    logic [adpcm_pkg::addr_w-1:0] end_a [adpcm_pkg::num_ch];
    logic [adpcm_pkg::addr_w-1:0] cur_a [adpcm_pkg::num_ch];
    logic [adpcm_pkg::num_ch-1:0] on_ch;
    logic [adpcm_pkg::num_ch-1:0] nib_hi;
    logic                         play;
    logic                         at_end;

    // key ops take the whole slot, no fetch then
    assign play   = on_ch[seq_ch] && seq_op != adpcm_pkg::op_key_on
                                  && seq_op != adpcm_pkg::op_key_off;
    assign at_end = cur_a[seq_ch] == end_a[seq_ch];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            on_ch     <= '0;
            nib_hi    <= '0;
            rom_oe_n  <= 1'b1;
            ac_ch     <= '0;
            ac_nib_hi <= 1'b0;
            ac_on     <= 1'b0;
            pan_wr    <= 1'b0;
        end else if (cen) begin
            rom_oe_n  <= ~play;
            ac_ch     <= seq_ch;          // travels with the rom byte
            ac_nib_hi <= nib_hi[seq_ch];
            ac_on     <= play;
            pan_wr    <= seq_op == adpcm_pkg::op_pan;
            case (seq_op)
                adpcm_pkg::op_key_on: begin
                    on_ch[seq_ch]  <= 1'b1;
                    nib_hi[seq_ch] <= 1'b1;   // high nibble first
                end
                adpcm_pkg::op_key_off: on_ch[seq_ch] <= 1'b0;
                default: ;
            endcase
            if (play) begin
                nib_hi[seq_ch] <= ~nib_hi[seq_ch];
                if (!nib_hi[seq_ch] && at_end) on_ch[seq_ch] <= 1'b0;  // last byte done
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cen) begin
            pan_ch  <= seq_ch;
            pan_val <= seq_val[7:0];
            if (play) rom_addr <= cur_a[seq_ch];
            case (seq_op)
                adpcm_pkg::op_start:  start_a[seq_ch] <= {seq_val, 8'h00};  // block * 256
                adpcm_pkg::op_end:    end_a[seq_ch]   <= {seq_val, 8'hff};  // last byte of block
                adpcm_pkg::op_key_on: cur_a[seq_ch]   <= start_a[seq_ch];
                default: ;
            endcase
            if (play && !nib_hi[seq_ch] && !at_end) begin
                cur_a[seq_ch] <= cur_a[seq_ch] + 1'b1;  // next byte after low nibble
            end
        end
    end

endmodule

// ==== adpcm_decoder.sv ====
`timescale 1ns/100ps

module adpcm_decoder (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                cen,
    input  logic [7:0]                          rom_data,
    input  logic [adpcm_pkg::ch_w-1:0]          ac_ch,
    input  logic                                ac_nib_hi,
    input  logic                                ac_on,
    output logic [adpcm_pkg::ch_w-1:0]          dec_ch,
    output logic signed [adpcm_pkg::dec_w-1:0]  dec_pcm,
    output logic                                dec_on
);

    logic signed [adpcm_pkg::dec_w-1:0] acc [adpcm_pkg::num_ch];
    logic [5:0]                         idx [adpcm_pkg::num_ch];  // 0..48
    logic [3:0]                         nib;
    logic [15:0]                        step;
    logic [15:0]                        prod;
    logic [adpcm_pkg::dec_w-1:0]        delta;
    logic signed [adpcm_pkg::dec_w-1:0] acc_nxt;
    logic signed [7:0]                  idx_sum;
    logic [5:0]                         idx_nxt;

    always_comb begin
        nib   = ac_nib_hi ? rom_data[7:4] : rom_data[3:0];
        step  = adpcm_pkg::step_table[idx[ac_ch]];
        prod  = step * {12'd0, nib[2:0], 1'b1};       // step * (2m+1)
        delta = prod[14:3];                           // /8, max 2910
        // wraps in 12 bits
        acc_nxt = nib[3] ? acc[ac_ch] - delta : acc[ac_ch] + delta;
        idx_sum = $signed({2'b00, idx[ac_ch]}) + adpcm_pkg::idx_adj[nib[2:0]];
        if (idx_sum < 0) idx_nxt = '0;
        else if (idx_sum > adpcm_pkg::step_idx_max) idx_nxt = 6'(adpcm_pkg::step_idx_max);
        else idx_nxt = idx_sum[5:0];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dec_ch  <= '0;
            dec_on  <= 1'b0;
            dec_pcm <= '0;
        end else if (cen) begin
            dec_ch  <= ac_ch;
            dec_on  <= ac_on;
            dec_pcm <= ac_on ? acc_nxt : '0;  // idle slot outputs silence
        end
    end

    // per-channel state, cleared by every idle slot
    always_ff @(posedge clk) begin
        if (cen) begin
            acc[ac_ch] <= ac_on ? acc_nxt : '0;
            idx[ac_ch] <= ac_on ? idx_nxt : '0;
        end
    end

endmodule

// ==== adpcm_drv_a.sv ====
`timescale 1ns/100ps

module adpcm_drv_a (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                cen,
    input  logic [5:0]                          atl,
    input  logic [adpcm_pkg::ch_w-1:0]          up_ch,
    input  logic                                up_start,
    input  logic                                up_end,
    input  logic                                up_lracl,
    input  logic [adpcm_pkg::reg_addr_w-1:0]    addr_in,
    input  logic [7:0]                          lracl_in,
    input  logic                                aon_wr,
    input  logic [7:0]                          aon_cmd,
    input  logic [7:0]                          rom_data,
    output logic [adpcm_pkg::addr_w-1:0]        rom_addr,
    output logic                                rom_oe_n,
    output logic signed [adpcm_pkg::pcm_w-1:0]  pcm_l,
    output logic signed [adpcm_pkg::pcm_w-1:0]  pcm_r,
    output logic                                sample_valid
);

    logic [adpcm_pkg::ch_w-1:0]         seq_ch, ac_ch, pan_ch, dec_ch, gain_ch;
    adpcm_pkg::reg_op_e                 seq_op;
    logic [adpcm_pkg::reg_addr_w-1:0]   seq_val;
    logic                               ac_nib_hi, ac_on, pan_wr, dec_on;
    logic [7:0]                         pan_val;
    logic signed [adpcm_pkg::dec_w-1:0] dec_pcm;
    logic signed [adpcm_pkg::pcm_w-1:0] gain_l, gain_r;

    adpcm_slot_seq u_seq (  // slot counter, pending writes
        .clk, .rst_n, .cen, .up_ch, .up_start, .up_end, .up_lracl,
        .addr_in, .lracl_in, .aon_wr, .aon_cmd, .seq_ch, .seq_op, .seq_val
    );

    adpcm_addr_cnt u_addr (  // rom fetch
        .clk, .rst_n, .cen, .seq_ch, .seq_op, .seq_val, .rom_addr, .rom_oe_n,
        .ac_ch, .ac_nib_hi, .ac_on, .pan_ch, .pan_wr, .pan_val
    );

    adpcm_decoder u_dec (
        .clk, .rst_n, .cen, .rom_data, .ac_ch, .ac_nib_hi, .ac_on,
        .dec_ch, .dec_pcm, .dec_on
    );

    adpcm_gain u_gain (
        .clk, .rst_n, .cen, .atl, .pan_ch, .pan_wr, .pan_val,
        .dec_ch, .dec_pcm, .dec_on, .gain_ch, .gain_l, .gain_r
    );

    adpcm_mix u_mix (  // one stereo sample per round
        .clk, .rst_n, .cen, .gain_ch, .gain_l, .gain_r, .pcm_l, .pcm_r, .sample_valid
    );

endmodule

// ==== adpcm_drv_a_chk.sv ====
`timescale 1ns/100ps

module adpcm_drv_a_chk (
    input logic                                clk,
    input logic                                rst_n,
    input logic                                cen,
    input logic [adpcm_pkg::addr_w-1:0]        rom_addr,
    input logic                                rom_oe_n,
    input logic signed [adpcm_pkg::pcm_w-1:0]  pcm_l,
    input logic signed [adpcm_pkg::pcm_w-1:0]  pcm_r,
    input logic                                sample_valid
);

    logic [2:0] cen_cnt;  // cen pulses since reset, stops at 7

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) cen_cnt <= '0;
        else if (cen && cen_cnt != 3'd7) cen_cnt <= cen_cnt + 1'b1;
    end

    // strobe is a single clk
    a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        sample_valid |=> !sample_valid)
        else $error("sample_valid wider than one clock");

    // first round after reset has nothing keyed on
    a_oe_idle: assert property (@(posedge clk) disable iff (!rst_n)
        cen_cnt <= 3'd6 |-> rom_oe_n)
        else $error("rom_oe_n low within the first round after reset");

    // rom model is 64 KB
    a_addr_range: assert property (@(posedge clk) disable iff (!rst_n)
        !rom_oe_n |-> rom_addr < 24'h01_0000)
        else $error("rom_addr beyond 64 KB");

    a_pcm_hold: assert property (@(posedge clk) disable iff (!rst_n)
        !sample_valid |-> $stable(pcm_l) && $stable(pcm_r))
        else $error("pcm output moved between strobes");

endmodule

bind adpcm_drv_a adpcm_drv_a_chk u_chk (
    .clk, .rst_n, .cen, .rom_addr, .rom_oe_n, .pcm_l, .pcm_r, .sample_valid
);

// ==== adpcm_gain.sv ====
`timescale 1ns/100ps

module adpcm_gain (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                cen,
    input  logic [5:0]                          atl,      // total level attenuation
    input  logic [adpcm_pkg::ch_w-1:0]          pan_ch,
    input  logic                                pan_wr,
    input  logic [7:0]                          pan_val,  // L, R, -, attenuation 4:0
    input  logic [adpcm_pkg::ch_w-1:0]          dec_ch,
    input  logic signed [adpcm_pkg::dec_w-1:0]  dec_pcm,
    input  logic                                dec_on,
    output logic [adpcm_pkg::ch_w-1:0]          gain_ch,
    output logic signed [adpcm_pkg::pcm_w-1:0]  gain_l,
    output logic signed [adpcm_pkg::pcm_w-1:0]  gain_r
);

    logic [7:0]                         lracl [adpcm_pkg::num_ch];
    logic [4:0]                         lvl;
    logic [5:0]                         tl;
    logic signed [17:0]                 mul_cl;
    logic signed [19:0]                 mul_tl;
    logic signed [12:0]                 sc_cl;
    logic signed [13:0]                 sc_tl;
    logic signed [adpcm_pkg::pcm_w-1:0] pcm_g;

    always_comb begin
        lvl    = 5'd31 - lracl[dec_ch][4:0];
        tl     = 6'd63 - atl;
        mul_cl = dec_pcm * $signed({1'b0, lvl});
        sc_cl  = mul_cl[17:5];                 // >>> 5
        mul_tl = sc_cl * $signed({1'b0, tl});
        sc_tl  = mul_tl[19:6];                 // >>> 6
        pcm_g  = 16'(sc_tl);                   // sign extend
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < adpcm_pkg::num_ch; i++) lracl[i] <= 8'h00;  // muted
            gain_ch <= '0;
            gain_l  <= '0;
            gain_r  <= '0;
        end else if (cen) begin
            if (pan_wr) lracl[pan_ch] <= pan_val;
            gain_ch <= dec_ch;
            gain_l  <= (dec_on && lracl[dec_ch][7]) ? pcm_g : '0;  // left
            gain_r  <= (dec_on && lracl[dec_ch][6]) ? pcm_g : '0;  // right
        end
    end

endmodule

// ==== adpcm_mix.sv ====
`timescale 1ns/100ps

module adpcm_mix (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                cen,
    input  logic [adpcm_pkg::ch_w-1:0]          gain_ch,
    input  logic signed [adpcm_pkg::pcm_w-1:0]  gain_l,
    input  logic signed [adpcm_pkg::pcm_w-1:0]  gain_r,
    output logic signed [adpcm_pkg::pcm_w-1:0]  pcm_l,
    output logic signed [adpcm_pkg::pcm_w-1:0]  pcm_r,
    output logic                                sample_valid
);

    logic signed [adpcm_pkg::pcm_w+2:0] sum_l, sum_r;  // 19 bits, six channels
    logic signed [adpcm_pkg::pcm_w+2:0] tot_l, tot_r;
    logic                               last;

    // clamp a round sum to the output range
    function automatic logic signed [adpcm_pkg::pcm_w-1:0] sat(
        input logic signed [adpcm_pkg::pcm_w+2:0] v
    );
        logic [3:0] top;
        top = v[adpcm_pkg::pcm_w+2:adpcm_pkg::pcm_w-1];
        if (&top || ~|top) return v[adpcm_pkg::pcm_w-1:0];  // in range
        return {v[adpcm_pkg::pcm_w+2], {(adpcm_pkg::pcm_w-1){~v[adpcm_pkg::pcm_w+2]}}};
    endfunction

    assign tot_l = sum_l + gain_l;
    assign tot_r = sum_r + gain_r;
    assign last  = int'(gain_ch) == adpcm_pkg::num_ch - 1;  // channel 5 closes the round

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_l        <= '0;
            sum_r        <= '0;
            pcm_l        <= '0;
            pcm_r        <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= cen && last;  // one clk wide
            if (cen) begin
                if (last) begin
                    pcm_l <= sat(tot_l);
                    pcm_r <= sat(tot_r);
                    sum_l <= '0;
                    sum_r <= '0;
                end else begin
                    sum_l <= tot_l;
                    sum_r <= tot_r;
                end
            end
        end
    end

endmodule

// ==== adpcm_pkg.sv ====
package adpcm_pkg;

    localparam int num_ch       = 6;   // adpcm-a channels
    localparam int ch_w         = 3;   // channel index
    localparam int addr_w       = 24;  // rom byte address
    localparam int reg_addr_w   = 16;  // start/end block number, 256 bytes each
    localparam int pcm_w        = 16;  // output sample
    localparam int dec_w        = 12;  // decoder accumulator
    localparam int step_idx_max = 48;

    // step sizes, one per step index
    localparam logic [15:0] step_table [0:step_idx_max] = '{
        16'd16,   16'd17,   16'd19,   16'd21,   16'd23,   16'd25,   16'd28,
        16'd31,   16'd34,   16'd37,   16'd41,   16'd45,   16'd50,   16'd55,
        16'd60,   16'd66,   16'd73,   16'd80,   16'd88,   16'd97,   16'd107,
        16'd118,  16'd130,  16'd143,  16'd157,  16'd173,  16'd190,  16'd209,
        16'd230,  16'd253,  16'd279,  16'd307,  16'd337,  16'd371,  16'd408,
        16'd449,  16'd494,  16'd544,  16'd598,  16'd658,  16'd724,  16'd796,
        16'd876,  16'd963,  16'd1060, 16'd1166, 16'd1282, 16'd1411, 16'd1552
    };

    // index move, looked up by the three magnitude bits
    localparam logic signed [4:0] idx_adj [0:7] = '{
        -5'sd1, -5'sd1, -5'sd1, -5'sd1,
        5'sd2,  5'sd5,  5'sd7,  5'sd9
    };

    // register operations handed from the sequencer to the datapath
    typedef enum logic [2:0] {
        op_none,
        op_start,    // start block number
        op_end,      // end block number
        op_pan,      // pan and channel level byte
        op_key_on,
        op_key_off
    } reg_op_e;

endpackage

// ==== adpcm_slot_seq.sv ====
`timescale 1ns/100ps

module adpcm_slot_seq (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              cen,
    input  logic [adpcm_pkg::ch_w-1:0]        up_ch,
    input  logic                              up_start,
    input  logic                              up_end,
    input  logic                              up_lracl,
    input  logic [adpcm_pkg::reg_addr_w-1:0]  addr_in,
    input  logic [7:0]                        lracl_in,
    input  logic                              aon_wr,
    input  logic [7:0]                        aon_cmd,   // bit 7 = key off, 5:0 = mask
    output logic [adpcm_pkg::ch_w-1:0]        seq_ch,
    output adpcm_pkg::reg_op_e                seq_op,
    output logic [adpcm_pkg::reg_addr_w-1:0]  seq_val
);

    logic [adpcm_pkg::ch_w-1:0]       slot;
    logic [adpcm_pkg::num_ch-1:0]     pend_start, pend_end, pend_pan, pend_on, pend_off;
    logic [adpcm_pkg::reg_addr_w-1:0] start_val [adpcm_pkg::num_ch];
    logic [adpcm_pkg::reg_addr_w-1:0] end_val [adpcm_pkg::num_ch];
    logic [7:0]                       lracl_val [adpcm_pkg::num_ch];
    logic                             up_ok;

    assign up_ok  = int'(up_ch) < adpcm_pkg::num_ch;  // drop writes to channels 6, 7
    assign seq_ch = slot;                             // the address counter serves this slot

    // one op per slot, key off first
    always_comb begin
        seq_op  = adpcm_pkg::op_none;
        seq_val = '0;
        if (pend_off[slot]) begin
            seq_op = adpcm_pkg::op_key_off;
        end else if (pend_start[slot]) begin
            seq_op  = adpcm_pkg::op_start;
            seq_val = start_val[slot];
        end else if (pend_end[slot]) begin
            seq_op  = adpcm_pkg::op_end;
            seq_val = end_val[slot];
        end else if (pend_on[slot]) begin
            seq_op = adpcm_pkg::op_key_on;
        end else if (pend_pan[slot]) begin
            seq_op  = adpcm_pkg::op_pan;
            seq_val = {8'h00, lracl_val[slot]};  // pan byte in the low half
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slot       <= '0;
            pend_start <= '0;
            pend_end   <= '0;
            pend_pan   <= '0;
            pend_on    <= '0;
            pend_off   <= '0;
        end else begin
            if (cen) begin
                if (int'(slot) == adpcm_pkg::num_ch - 1) slot <= '0;
                else slot <= slot + 1'b1;
                case (seq_op)  // delivered op leaves the queue
                    adpcm_pkg::op_key_off: pend_off[slot]   <= 1'b0;
                    adpcm_pkg::op_start:   pend_start[slot] <= 1'b0;
                    adpcm_pkg::op_end:     pend_end[slot]   <= 1'b0;
                    adpcm_pkg::op_key_on:  pend_on[slot]    <= 1'b0;
                    adpcm_pkg::op_pan:     pend_pan[slot]   <= 1'b0;
                    default: ;
                endcase
            end
            // a write in the delivery cycle stays pending
            if (up_start && up_ok) pend_start[up_ch] <= 1'b1;
            if (up_end && up_ok)   pend_end[up_ch]   <= 1'b1;
            if (up_lracl && up_ok) pend_pan[up_ch]   <= 1'b1;
            if (aon_wr) begin
                for (int i = 0; i < adpcm_pkg::num_ch; i++) begin
                    if (aon_cmd[i]) begin
                        pend_off[i] <= aon_cmd[7];   // last key command wins
                        pend_on[i]  <= ~aon_cmd[7];
                    end
                end
            end
        end
    end

    // write values, newest replaces older
    always_ff @(posedge clk) begin
        if (up_start && up_ok) start_val[up_ch] <= addr_in;
        if (up_end && up_ok)   end_val[up_ch]   <= addr_in;
        if (up_lracl && up_ok) lracl_val[up_ch] <= lracl_in;
    end

endmodule

// ==== filelist.f ====
adpcm_pkg.sv
adpcm_slot_seq.sv
adpcm_addr_cnt.sv
adpcm_decoder.sv
adpcm_gain.sv
adpcm_mix.sv
adpcm_drv_a.sv
adpcm_drv_a_chk.sv
tb_adpcm_drv_a.sv

// ==== tb_adpcm_drv_a.sv ====
`timescale 1ns/100ps

module tb_adpcm_drv_a;

    logic                                clk, rst_n, cen;
    logic [5:0]                          atl;
    logic [adpcm_pkg::ch_w-1:0]          up_ch;
    logic                                up_start, up_end, up_lracl, aon_wr;
    logic [adpcm_pkg::reg_addr_w-1:0]    addr_in;
    logic [7:0]                          lracl_in, aon_cmd, rom_data;
    logic [adpcm_pkg::addr_w-1:0]        rom_addr;
    logic                                rom_oe_n, sample_valid;
    logic signed [adpcm_pkg::pcm_w-1:0]  pcm_l, pcm_r;

    logic [7:0]  rom [0:65535];
    logic [31:0] lcg_state;
    int          cen_div;

    // reference state per channel
    int          m_acc [6], m_idx [6], m_wait [6], m_kill [6];
    logic        m_on [6], m_nibhi [6];
    logic [23:0] m_addr [6], m_start [6], m_end [6];
    logic [7:0]  m_pan [6];
    int          m_atl;

    adpcm_drv_a UUT (
        .clk, .rst_n, .cen, .atl, .up_ch, .up_start, .up_end, .up_lracl,
        .addr_in, .lracl_in, .aon_wr, .aon_cmd, .rom_data,
        .rom_addr, .rom_oe_n, .pcm_l, .pcm_r, .sample_valid
    );

    // 64 KB with upper bits ignored
    // reads as zero while the output enable is off
    assign rom_data = rom_oe_n ? 8'h00 : rom[rom_addr[15:0]];

    always #50 clk = ~clk;

    // cen on every third clock
    always @(posedge clk) begin
        #5;
        cen = (cen_div == 2);
        cen_div = (cen_div + 1) % 3;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // one ADPCM-A nibble into the channel accumulator, returns the new sample
    function automatic int decode_nibble(input int c, input logic [3:0] nib);
        int               delta;
        logic signed [11:0] w;
        delta = int'(adpcm_pkg::step_table[m_idx[c]]) * (2 * int'(nib[2:0]) + 1) / 8;
        m_acc[c] = nib[3] ? m_acc[c] - delta : m_acc[c] + delta;
        w = m_acc[c][11:0];                 // 12-bit wrap
        m_acc[c] = w;
        m_idx[c] = m_idx[c] + adpcm_pkg::idx_adj[nib[2:0]];
        if (m_idx[c] < 0) m_idx[c] = 0;
        if (m_idx[c] > adpcm_pkg::step_idx_max) m_idx[c] = adpcm_pkg::step_idx_max;
        return m_acc[c];
    endfunction

    // one round of one channel: fetch, decode, move the address
    function automatic int step_channel(input int c);
        logic [7:0] b;
        logic [3:0] nib;
        int         smp;
        if (!m_on[c]) return 0;
        if (m_kill[c] == 0) begin       // key off reached its slot
            m_on[c] = 1'b0;
            m_kill[c] = -1;
            return 0;
        end
        if (m_kill[c] > 0) m_kill[c]--;
        if (m_wait[c] > 0) begin        // key on slot, no fetch yet
            m_wait[c]--;
            return 0;
        end
        b = rom[m_addr[c][15:0]];
        nib = m_nibhi[c] ? b[7:4] : b[3:0];
        smp = decode_nibble(c, nib);
        if (!m_nibhi[c]) begin
            if (m_addr[c] == m_end[c]) m_on[c] = 1'b0;
            else m_addr[c]++;
        end
        m_nibhi[c] = !m_nibhi[c];
        return smp;
    endfunction

    function automatic int apply_gain(input int pcm, input logic [7:0] pan, input int tl);
        int v;
        v = (pcm * (31 - int'(pan[4:0]))) >>> 5;
        return (v * (63 - tl)) >>> 6;
    endfunction

    function automatic int sat16(input int v);
        if (v > 32767) return 32767;
        if (v < -32768) return -32768;
        return v;
    endfunction

    task automatic check_val(input string name, input int expv, input int actv);
        if (expv !== actv) begin
            $display("** Error at %0t ns: %s expected %0d, got %0d", $time, name, expv, actv);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // returns 5 ns after the edge that raised sample_valid
    task automatic wait_sample();
        int n;
        n = 0;
        do begin
            @(posedge clk);
            #5;
            n++;
            if (n > 40) begin
                $display("no sample_valid strobe within 40 clocks");
                $display("Simulation FAILED");
                $fatal(1, "timeout");
            end
        end while (!sample_valid);
    endtask

    task automatic run_rounds(input int n);
        int  sl, sr, smp;
        bit  any_on;
        for (int r = 0; r < n; r++) begin
            wait_sample();
            sl = 0;
            sr = 0;
            any_on = 1'b0;
            for (int c = 0; c < 6; c++) begin
                smp = apply_gain(step_channel(c), m_pan[c], m_atl);
                if (m_pan[c][7]) sl += smp;
                if (m_pan[c][6]) sr += smp;
                any_on |= m_on[c];
            end
            check_val("pcm_l", sat16(sl), pcm_l);
            check_val("pcm_r", sat16(sr), pcm_r);
            if (!any_on) check_val("rom_oe_n", 1, rom_oe_n);  // nothing to fetch
        end
    endtask

    // start, end and pan of one idle channel, one strobe per clock
    task automatic set_channel(input int c, input logic [15:0] blk_s,
                               input logic [15:0] blk_e, input logic [7:0] pan);
        up_ch = c[2:0];
        addr_in = blk_s;
        up_start = 1'b1;
        @(posedge clk);
        #5 up_start = 1'b0;
        addr_in = blk_e;
        up_end = 1'b1;
        @(posedge clk);
        #5 up_end = 1'b0;
        lracl_in = pan;
        up_lracl = 1'b1;
        @(posedge clk);
        #5 up_lracl = 1'b0;
        m_start[c] = {blk_s, 8'h00};
        m_end[c] = {blk_e, 8'hff};
        m_pan[c] = pan;
    endtask

    // key on or off by mask; low slots are served one round later
    task automatic key_cmd(input bit off, input logic [5:0] mask);
        aon_cmd = {off, 1'b0, mask};
        aon_wr = 1'b1;
        @(posedge clk);
        #5 aon_wr = 1'b0;
        for (int c = 0; c < 6; c++) begin
            if (mask[c] && off) m_kill[c] = (c >= 3) ? 0 : 1;
            if (mask[c] && !off) begin
                m_on[c] = 1'b1;
                m_wait[c] = (c >= 3) ? 1 : 2;
                m_kill[c] = -1;
                m_addr[c] = m_start[c];
                m_nibhi[c] = 1'b1;
                m_acc[c] = 0;
                m_idx[c] = 0;
            end
        end
    endtask

    function automatic logic [15:0] rand_blk();
        lcg_state = lcg_next(lcg_state);
        return {8'h00, 8'(lcg_state[23:16] % 200)};
    endfunction

    initial begin
        logic [15:0] b;
        clk      = 0;
        rst_n    = 0;
        cen      = 0;
        cen_div  = 0;
        atl      = 0;
        up_ch    = 0;
        up_start = 0;
        up_end   = 0;
        up_lracl = 0;
        addr_in  = 0;
        lracl_in = 0;
        aon_wr   = 0;
        aon_cmd  = 0;
        lcg_state = 32'h2357_173f;
        for (int i = 0; i < 65536; i++) begin
            lcg_state = lcg_next(lcg_state);
            rom[i] = lcg_state[31:24] ^ i[7:0] ^ i[15:8];
        end
        for (int c = 0; c < 6; c++) begin
            m_on[c]    = 0;
            m_kill[c]  = -1;
            m_wait[c]  = 0;
            m_pan[c]   = 8'h00;
            m_acc[c]   = 0;
            m_idx[c]   = 0;
            m_nibhi[c] = 1;
            m_start[c] = 0;
            m_end[c]   = 0;
            m_addr[c]  = 0;
        end
        m_atl = 0;
        repeat (5) @(posedge clk);
        #5 rst_n = 1;

        run_rounds(4);                          // idle after reset

        b = rand_blk();                         // one channel, both sides
        set_channel(0, b, b + 1, 8'hc0);
        run_rounds(5);
        key_cmd(0, 6'b000001);
        run_rounds(40);
        key_cmd(1, 6'b000001);
        run_rounds(3);

        b = rand_blk();                         // left only and right only
        set_channel(1, b, b + 1, 8'h80);
        b = rand_blk();
        set_channel(4, b, b + 1, 8'h40);
        run_rounds(5);
        key_cmd(0, 6'b010010);
        run_rounds(30);
        key_cmd(1, 6'b010010);
        run_rounds(3);

        atl = 6'd20;                            // channel and total level
        m_atl = 20;
        b = rand_blk();
        set_channel(2, b, b + 1, 8'hc7);
        b = rand_blk();
        set_channel(5, b, b + 1, 8'hd5);
        run_rounds(5);
        key_cmd(0, 6'b100100);
        run_rounds(30);
        key_cmd(1, 6'b100100);
        run_rounds(3);
        atl = 6'd0;
        m_atl = 0;

        b = rand_blk();                         // one block to its end
        set_channel(3, b, b, 8'hc0);
        run_rounds(5);
        key_cmd(0, 6'b001000);
        run_rounds(520);
        b = rand_blk();                         // key off during play
        set_channel(0, b, b + 2, 8'hc0);
        run_rounds(5);
        key_cmd(0, 6'b000001);
        run_rounds(20);
        key_cmd(1, 6'b000001);
        run_rounds(4);

        for (int c = 0; c < 6; c++) begin      // all six at full level
            b = rand_blk();
            set_channel(c, b, b + 1, 8'hc0);
        end
        run_rounds(6);
        key_cmd(0, 6'b111111);
        run_rounds(40);
        key_cmd(1, 6'b111111);
        run_rounds(4);

        $display("Simulation PASSED");
        $finish;
    end

endmodule
